//--- hdl/ex_alu.sv
/*
  Single-cycle ALU replica of the execute stage.
  Computes add, subtract, logic, shift and set-less-than results and the
  branch comparison. Outputs are forced to zero while the unit is idle.
*/

`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  logic    enable_i,
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  localparam int unsigned SHAMT_W = $clog2(DATA_W);

  logic               signed_cmp;
  logic [DATA_W:0]    diff;
  logic               lt;
  logic               eq;
  logic [SHAMT_W-1:0] shamt;
  word_t              res;
  logic               cmp;

  // One extended subtractor serves SUB and all less-than tests
  assign signed_cmp = operator_i inside {ALU_SLTS, ALU_LTS, ALU_GES};
  assign diff = {signed_cmp & operand_a_i[DATA_W-1], operand_a_i}
              - {signed_cmp & operand_b_i[DATA_W-1], operand_b_i};
  assign lt    = diff[DATA_W];
  assign eq    = (operand_a_i == operand_b_i);
  assign shamt = operand_b_i[SHAMT_W-1:0];

  always_comb begin : alu_mux
    res = '0;
    cmp = 1'b0;
    case (operator_i)
      ALU_ADD:  res = operand_a_i + operand_b_i;
      ALU_SUB:  res = diff[DATA_W-1:0];
      ALU_AND:  res = operand_a_i & operand_b_i;
      ALU_OR:   res = operand_a_i | operand_b_i;
      ALU_XOR:  res = operand_a_i ^ operand_b_i;
      ALU_SLL:  res = operand_a_i << shamt;
      ALU_SRL:  res = operand_a_i >> shamt;
      ALU_SRA:  res = word_t'($signed(operand_a_i) >>> shamt);
      ALU_SLTS, ALU_SLTU: begin
        cmp = lt;
        res = {{(DATA_W-1){1'b0}}, lt};
      end
      ALU_LTS, ALU_LTU: cmp = lt;
      ALU_GES, ALU_GEU: cmp = ~lt;
      ALU_EQ:   cmp = eq;
      ALU_NE:   cmp = ~eq;
    endcase
  end

  // Idle replicas present a quiet, identical output to the voter
  assign result_o     = enable_i ? res : '0;
  assign cmp_result_o = enable_i & cmp;

endmodule

//--- hdl/ex_mult_datapath.sv
/*
  Multiplier datapath replica.
  MUL returns the low product combinationally. The high products
  accumulate operand a times one slice of operand b per step into a
  double-width accumulator whose upper word is the result.
*/

`timescale 1ns/1ps

module ex_mult_datapath
  import ex_pkg::*;
#(
  parameter int unsigned MULT_SLICE_W = 8
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  mult_op_e                                 operator_i,
  input  word_t                                    op_a_i,
  input  word_t                                    op_b_i,
  input  logic                                     load_i,
  input  logic                                     step_i,
  input  logic [$clog2(DATA_W / MULT_SLICE_W)-1:0] step_idx_i,
  output word_t                                    result_o
);

  localparam int unsigned STEPS = DATA_W / MULT_SLICE_W;
  localparam int unsigned IDX_W = $clog2(STEPS);
  localparam int unsigned ACC_W = 2 * DATA_W;
  localparam int unsigned PP_W  = DATA_W + MULT_SLICE_W + 2;

  logic signed [DATA_W:0]       a_q;
  word_t                        b_q;
  logic                         b_signed_q;
  logic [ACC_W-1:0]             acc_q;
  logic                         a_signed;
  logic                         b_signed;
  logic [MULT_SLICE_W-1:0]      slice;
  logic signed [MULT_SLICE_W:0] slice_s;
  logic signed [PP_W-1:0]       pp;
  logic signed [ACC_W-1:0]      pp_ext;
  word_t                        low_prod;

  assign a_signed = operator_i inside {MULT_MULH, MULT_MULHSU};
  assign b_signed = (operator_i == MULT_MULH);

  // Only the top slice of a signed b carries the sign weight
  assign slice   = b_q[step_idx_i * MULT_SLICE_W +: MULT_SLICE_W];
  assign slice_s = {b_signed_q & (step_idx_i == IDX_W'(STEPS - 1)) & slice[MULT_SLICE_W-1],
                    slice};

  assign pp     = a_q * slice_s;
  assign pp_ext = pp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q        <= '0;
      b_q        <= '0;
      b_signed_q <= 1'b0;
      acc_q      <= '0;
    end else if (load_i) begin
      a_q        <= {a_signed & op_a_i[DATA_W-1], op_a_i};
      b_q        <= op_b_i;
      b_signed_q <= b_signed;
      acc_q      <= '0;
    end else if (step_i) begin
      acc_q <= acc_q + ACC_W'(pp_ext << (step_idx_i * MULT_SLICE_W));
    end
  end

  assign low_prod = op_a_i * op_b_i;
  assign result_o = (operator_i == MULT_MUL) ? low_prod : acc_q[ACC_W-1:DATA_W];

endmodule

//--- hdl/ex_mult_fsm.sv
/*
  Sequencer for the multicycle high-product multiplications.
  Loads the datapath, walks the slice index across the steps and holds
  the result in DONE until the stage accepts it. MUL stays in IDLE.
*/

`timescale 1ns/1ps

module ex_mult_fsm
  import ex_pkg::*;
#(
  parameter int unsigned MULT_SLICE_W = 8
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     enable_i,
  input  mult_op_e                                 operator_i,
  input  logic                                     ex_ready_i,
  output logic                                     load_o,
  output logic                                     step_o,
  output logic                                     ready_o,
  output logic                                     busy_o,
  output logic [$clog2(DATA_W / MULT_SLICE_W)-1:0] step_idx_o
);

  localparam int unsigned STEPS = DATA_W / MULT_SLICE_W;
  localparam int unsigned IDX_W = $clog2(STEPS);

  typedef enum logic [1:0] {
    IDLE,
    STEP,
    DONE
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic [IDX_W-1:0] cnt_q;
  logic [IDX_W-1:0] cnt_d;
  logic             start;
  logic             last;

  assign start = enable_i & (operator_i != MULT_MUL);
  assign last  = (cnt_q == IDX_W'(STEPS - 1));

  always_comb begin : fsm_next
    state_d = state_q;
    cnt_d   = cnt_q;
    load_o  = 1'b0;
    step_o  = 1'b0;
    ready_o = 1'b1;
    case (state_q)
      IDLE: begin
        // Ready drops in the same cycle a high product shows up
        if (start) begin
          load_o  = 1'b1;
          ready_o = 1'b0;
          cnt_d   = '0;
          state_d = STEP;
        end
      end
      STEP: begin
        step_o  = 1'b1;
        ready_o = 1'b0;
        if (last) begin
          cnt_d   = '0;
          state_d = DONE;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      DONE: begin
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign busy_o     = (state_q != IDLE);
  assign step_idx_o = cnt_q;

endmodule

//--- hdl/ex_pkg.sv
/*
  Shared definitions for the triplicated execute stage.
  Holds the data and register address widths, the ALU and multiplier
  opcodes and the payload structs that the majority voters compare.
*/

package ex_pkg;

  // Datapath widths
  parameter int unsigned DATA_W     = 32;
  parameter int unsigned REG_ADDR_W = 6;

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLTS = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LTS  = 4'd12,
    ALU_LTU  = 4'd13,
    ALU_GES  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // MUL is single cycle, the three high products are sequenced
  typedef enum logic [1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

  //////////////////////////////
  // Voter payloads
  //////////////////////////////

  typedef struct packed {
    word_t result;
    logic  cmp;
  } alu_vote_t;

  typedef struct packed {
    word_t result;
    logic  ready;
    logic  busy;
  } mult_vote_t;

endpackage

//--- hdl/ex_stage.sv
/*
  Execute stage with triplicated ALU and multiplier.
  Each set of replicas is majority voted with per-copy fault flags. The
  voted results drive the write ports and the ex_ready/ex_valid handshake.
*/

`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int unsigned MULT_SLICE_W = 8
) (
  input  logic      clk,
  input  logic      rst_n,

  // ALU and multiplier operands from ID
  input  logic      alu_en_i,
  input  alu_op_e   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,
  input  logic      mult_en_i,
  input  mult_op_e  mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,

  // CSR and LSU
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  word_t     lsu_rdata_i,

  input  logic      branch_in_ex_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,

  // Handshake
  input  logic      wb_ready_i,
  output logic      ex_ready_o,
  output logic      ex_valid_o,

  output logic      branch_decision_o,
  output word_t     jump_target_o,

  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,

  output logic      alu_faulty_1_o,
  output logic      alu_faulty_2_o,
  output logic      alu_faulty_3_o,
  output logic      mult_faulty_o
);

  localparam int unsigned IDX_W = $clog2(DATA_W / MULT_SLICE_W);

  alu_vote_t  [2:0] alu_copy;
  mult_vote_t [2:0] mult_copy;
  alu_vote_t        alu_voted;
  mult_vote_t       mult_voted;
  logic       [2:0] mult_faulty;

  //////////////////////////////
  // Replicas
  //////////////////////////////

  for (genvar g = 0; g < 3; g++) begin : gen_replica
    word_t            alu_res;
    logic             alu_cmp;
    logic             mult_load;
    logic             mult_step;
    logic             mult_ready;
    logic             mult_busy;
    logic [IDX_W-1:0] mult_idx;
    word_t            mult_res;

    ex_alu u_alu (
      .enable_i    (alu_en_i),
      .operator_i  (alu_operator_i),
      .operand_a_i (alu_operand_a_i),
      .operand_b_i (alu_operand_b_i),
      .result_o    (alu_res),
      .cmp_result_o(alu_cmp)
    );

    ex_mult_fsm #(
      .MULT_SLICE_W(MULT_SLICE_W)
    ) u_mult_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable_i  (mult_en_i),
      .operator_i(mult_operator_i),
      .ex_ready_i(ex_ready_o),
      .load_o    (mult_load),
      .step_o    (mult_step),
      .ready_o   (mult_ready),
      .busy_o    (mult_busy),
      .step_idx_o(mult_idx)
    );

    ex_mult_datapath #(
      .MULT_SLICE_W(MULT_SLICE_W)
    ) u_mult_dp (
      .clk       (clk),
      .rst_n     (rst_n),
      .operator_i(mult_operator_i),
      .op_a_i    (mult_operand_a_i),
      .op_b_i    (mult_operand_b_i),
      .load_i    (mult_load),
      .step_i    (mult_step),
      .step_idx_i(mult_idx),
      .result_o  (mult_res)
    );

    assign alu_copy[g]  = '{result: alu_res, cmp: alu_cmp};
    assign mult_copy[g] = '{result: mult_res, ready: mult_ready, busy: mult_busy};
  end

  //////////////////////////////
  // Voters
  //////////////////////////////

  ex_tmr_voter #(
    .payload_t(alu_vote_t)
  ) u_alu_voter (
    .copy_1_i  (alu_copy[0]),
    .copy_2_i  (alu_copy[1]),
    .copy_3_i  (alu_copy[2]),
    .voted_o   (alu_voted),
    .faulty_1_o(alu_faulty_1_o),
    .faulty_2_o(alu_faulty_2_o),
    .faulty_3_o(alu_faulty_3_o)
  );

  ex_tmr_voter #(
    .payload_t(mult_vote_t)
  ) u_mult_voter (
    .copy_1_i  (mult_copy[0]),
    .copy_2_i  (mult_copy[1]),
    .copy_3_i  (mult_copy[2]),
    .voted_o   (mult_voted),
    .faulty_1_o(mult_faulty[0]),
    .faulty_2_o(mult_faulty[1]),
    .faulty_3_o(mult_faulty[2])
  );

  assign mult_faulty_o = |mult_faulty;

  ex_writeback u_writeback (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .alu_en_i              (alu_en_i),
    .mult_en_i             (mult_en_i),
    .csr_access_i          (csr_access_i),
    .alu_result_i          (alu_voted.result),
    .mult_result_i         (mult_voted.result),
    .csr_rdata_i           (csr_rdata_i),
    .lsu_rdata_i           (lsu_rdata_i),
    .regfile_alu_we_i      (regfile_alu_we_i),
    .regfile_alu_waddr_i   (regfile_alu_waddr_i),
    .regfile_we_i          (regfile_we_i),
    .regfile_waddr_i       (regfile_waddr_i),
    .lsu_err_i             (lsu_err_i),
    .ex_valid_i            (ex_valid_o),
    .wb_ready_i            (wb_ready_i),
    .regfile_alu_we_fw_o   (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o),
    .regfile_we_wb_o       (regfile_we_wb_o),
    .regfile_waddr_wb_o    (regfile_waddr_wb_o),
    .regfile_wdata_wb_o    (regfile_wdata_wb_o)
  );

  // Branch outcome to IF
  assign branch_decision_o = alu_voted.cmp;
  assign jump_target_o     = alu_operand_c_i;

  // The ALU finishes every operation in one cycle, so its ready is always high.
  // A branch in EX completes without WB and skips readiness.
  assign ex_ready_o = (mult_voted.ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                    & mult_voted.ready & lsu_ready_ex_i & wb_ready_i;

endmodule

//--- hdl/ex_tmr_voter.sv
/*
  Majority voter over three copies of any payload type.
  Passes the value shared by at least two copies and flags each copy that
  differs. With no majority copy 1 is passed and all copies are flagged.
*/

`timescale 1ns/1ps

module ex_tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t copy_1_i,
  input  payload_t copy_2_i,
  input  payload_t copy_3_i,
  output payload_t voted_o,
  output logic     faulty_1_o,
  output logic     faulty_2_o,
  output logic     faulty_3_o
);

  logic eq_12;
  logic eq_13;
  logic eq_23;
  logic no_majority;

  assign eq_12 = (copy_1_i == copy_2_i);
  assign eq_13 = (copy_1_i == copy_3_i);
  assign eq_23 = (copy_2_i == copy_3_i);
  assign no_majority = ~(eq_12 | eq_13 | eq_23);

  always_comb begin : vote
    if (eq_12 || eq_13) begin
      voted_o = copy_1_i;
    end else if (eq_23) begin
      voted_o = copy_2_i;
    end else begin
      voted_o = copy_1_i;
    end
  end

  // Disagreement flags per copy
  assign faulty_1_o = no_majority | (copy_1_i != voted_o);
  assign faulty_2_o = no_majority | (copy_2_i != voted_o);
  assign faulty_3_o = no_majority | (copy_3_i != voted_o);

endmodule

//--- hdl/ex_writeback.sv
/*
  Write ports of the execute stage.
  Selects the forward data for ID from CSR, multiplier or ALU and keeps
  the EX/WB register that drives the load write port toward the regfile.
*/

`timescale 1ns/1ps

module ex_writeback
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  word_t     lsu_rdata_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      lsu_err_i,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o
);

  logic      we_lsu_q;
  reg_addr_t waddr_lsu_q;

  //////////////////////////////
  // Forward port to ID
  //////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over the multiplier, which wins over the ALU
  always_comb begin : fw_data_mux
    regfile_alu_wdata_fw_o = '0;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q    <= 1'b0;
      waddr_lsu_q <= '0;
    end else if (ex_valid_i) begin
      // Valid already implies WB is ready
      we_lsu_q    <= regfile_we_i & ~lsu_err_i;
      waddr_lsu_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      // Nothing new arrives, so the slot drains
      we_lsu_q <= 1'b0;
    end
  end

  // Load data comes back from the LSU while the write is in WB
  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_ex_stage -o sim_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_ex_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi

//--- tb.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult_fsm.sv
hdl/ex_mult_datapath.sv
hdl/ex_tmr_voter.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
tests/tb_clk_gen.sv
tests/tb_ex_stage.sv

//--- tests/tb_clk_gen.sv
/*
  Free-running clock for the execute stage testbench.
  Starts low and toggles every half period.
*/

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- tests/tb_ex_stage.sv
/*
  Testbench for the triplicated execute stage.
  Drives random ALU, multiplier, CSR and LSU traffic from a fixed seed and
  checks the forward port, the load write port, the handshake and the
  fault flags against a model of the stage's rules.
*/

`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int unsigned SLICE_W      = 8;
  localparam int unsigned STEPS        = DATA_W / SLICE_W;
  localparam int unsigned CLK_NS       = 100;
  localparam int unsigned DRIVE_DELAY  = 10;
  localparam int unsigned SAMPLE_DELAY = 70;
  localparam int unsigned N_ALU        = 40;
  localparam int unsigned N_MUL        = 20;
  localparam int unsigned N_HIGH       = 24;
  localparam int unsigned N_BP         = 24;
  localparam int unsigned N_FWD        = 40;
  localparam int unsigned N_LOAD       = 40;
  localparam int unsigned N_OPS        = N_ALU + N_MUL + N_HIGH + N_BP + N_FWD + N_LOAD;
  localparam int unsigned TIMEOUT_NS   = (N_OPS * (STEPS + 4) + 200) * CLK_NS;

  logic      clk;
  logic      rst_n;
  logic      alu_en_i;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      mult_en_i;
  mult_op_e  mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  word_t     lsu_rdata_i;
  logic      branch_in_ex_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      wb_ready_i;
  logic      ex_ready_o;
  logic      ex_valid_o;
  logic      branch_decision_o;
  word_t     jump_target_o;
  logic      regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  word_t     regfile_wdata_wb_o;
  logic      alu_faulty_1_o;
  logic      alu_faulty_2_o;
  logic      alu_faulty_3_o;
  logic      mult_faulty_o;

  // EX/WB register model
  logic      we_model;
  reg_addr_t waddr_model;

  tb_clk_gen #(
    .PERIOD_NS(CLK_NS)
  ) u_clk_gen (
    .clk_o(clk)
  );

  ex_stage #(
    .MULT_SLICE_W(SLICE_W)
  ) u_ex_stage (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .alu_en_i              (alu_en_i),
    .alu_operator_i        (alu_operator_i),
    .alu_operand_a_i       (alu_operand_a_i),
    .alu_operand_b_i       (alu_operand_b_i),
    .alu_operand_c_i       (alu_operand_c_i),
    .mult_en_i             (mult_en_i),
    .mult_operator_i       (mult_operator_i),
    .mult_operand_a_i      (mult_operand_a_i),
    .mult_operand_b_i      (mult_operand_b_i),
    .csr_access_i          (csr_access_i),
    .csr_rdata_i           (csr_rdata_i),
    .lsu_en_i              (lsu_en_i),
    .lsu_ready_ex_i        (lsu_ready_ex_i),
    .lsu_err_i             (lsu_err_i),
    .lsu_rdata_i           (lsu_rdata_i),
    .branch_in_ex_i        (branch_in_ex_i),
    .regfile_alu_we_i      (regfile_alu_we_i),
    .regfile_alu_waddr_i   (regfile_alu_waddr_i),
    .regfile_we_i          (regfile_we_i),
    .regfile_waddr_i       (regfile_waddr_i),
    .wb_ready_i            (wb_ready_i),
    .ex_ready_o            (ex_ready_o),
    .ex_valid_o            (ex_valid_o),
    .branch_decision_o     (branch_decision_o),
    .jump_target_o         (jump_target_o),
    .regfile_alu_we_fw_o   (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o),
    .regfile_we_wb_o       (regfile_we_wb_o),
    .regfile_waddr_wb_o    (regfile_waddr_wb_o),
    .regfile_wdata_wb_o    (regfile_wdata_wb_o),
    .alu_faulty_1_o        (alu_faulty_1_o),
    .alu_faulty_2_o        (alu_faulty_2_o),
    .alu_faulty_3_o        (alu_faulty_3_o),
    .mult_faulty_o         (mult_faulty_o)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Comparison bit on top, result word below
  function automatic logic [DATA_W:0] alu_model(alu_op_e op, word_t a, word_t b);
    word_t      r;
    logic       c;
    logic [4:0] sh;
    r  = '0;
    c  = 1'b0;
    sh = b[4:0];
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_SLL:  r = a << sh;
      ALU_SRL:  r = a >> sh;
      ALU_SRA:  r = $signed(a) >>> sh;
      ALU_SLTS: c = $signed(a) < $signed(b);
      ALU_SLTU: c = a < b;
      ALU_EQ:   c = a == b;
      ALU_NE:   c = a != b;
      ALU_LTS:  c = $signed(a) < $signed(b);
      ALU_LTU:  c = a < b;
      ALU_GES:  c = $signed(a) >= $signed(b);
      default:  c = a >= b;
    endcase
    if (op == ALU_SLTS || op == ALU_SLTU) begin
      r = {31'b0, c};
    end
    return {c, r};
  endfunction

  function automatic word_t mult_model(mult_op_e op, word_t a, word_t b);
    logic               sa;
    logic               sb;
    logic signed [65:0] ea;
    logic signed [65:0] eb;
    logic signed [65:0] p;
    sa = (op == MULT_MULH) || (op == MULT_MULHSU);
    sb = (op == MULT_MULH);
    ea = {{34{sa & a[31]}}, a};
    eb = {{34{sb & b[31]}}, b};
    p  = ea * eb;
    if (op == MULT_MUL) begin
      return a * b;
    end
    return p[63:32];
  endfunction

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      fail_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      fail_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic settle_outputs();
    #(SAMPLE_DELAY);
  endtask

  // Checks common to every cycle, then steps to the next drive point
  task automatic close_cycle(input logic mult_rdy);
    logic exp_ready;
    logic exp_valid;
    exp_ready = (mult_rdy & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
    exp_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
              & mult_rdy & lsu_ready_ex_i & wb_ready_i;
    check_bit("alu_faulty_1_o", alu_faulty_1_o, 1'b0);
    check_bit("alu_faulty_2_o", alu_faulty_2_o, 1'b0);
    check_bit("alu_faulty_3_o", alu_faulty_3_o, 1'b0);
    check_bit("mult_faulty_o", mult_faulty_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, exp_ready);
    check_bit("ex_valid_o", ex_valid_o, exp_valid);
    check_bit("regfile_we_wb_o", regfile_we_wb_o, we_model);
    check_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(waddr_model));
    check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
    if (exp_valid) begin
      we_model    = regfile_we_i & ~lsu_err_i;
      waddr_model = regfile_waddr_i;
    end else if (wb_ready_i) begin
      we_model = 1'b0;
    end
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic idle_inputs();
    alu_en_i            = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MULT_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    lsu_rdata_i         = '0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  function automatic logic rand_bit();
    return 1'($urandom_range(0, 1));
  endfunction

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic run_alu_ops();
    logic [DATA_W:0] exp;
    repeat (N_ALU) begin
      idle_inputs();
      alu_en_i        = 1'b1;
      alu_operator_i  = alu_op_e'(4'($urandom_range(0, 15)));
      alu_operand_a_i = $urandom();
      alu_operand_b_i = $urandom();
      alu_operand_c_i = $urandom();
      exp = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      settle_outputs();
      check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp[DATA_W-1:0]);
      check_bit("branch_decision_o", branch_decision_o, exp[DATA_W]);
      check_word("jump_target_o", jump_target_o, alu_operand_c_i);
      close_cycle(1'b1);
    end
  endtask

  task automatic run_mul_ops();
    repeat (N_MUL) begin
      idle_inputs();
      mult_en_i        = 1'b1;
      mult_operand_a_i = $urandom();
      mult_operand_b_i = $urandom();
      settle_outputs();
      check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                 mult_model(MULT_MUL, mult_operand_a_i, mult_operand_b_i));
      close_cycle(1'b1);
    end
  endtask

  // High product, ready expected STEPS+1 cycles after the first enable cycle
  task automatic run_high_product(input logic backpressure);
    word_t exp;
    int    k;
    logic  rdy;
    logic  accepted;
    idle_inputs();
    mult_en_i        = 1'b1;
    mult_operator_i  = mult_op_e'(2'($urandom_range(1, 3)));
    mult_operand_a_i = $urandom();
    mult_operand_b_i = $urandom();
    exp      = mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
    k        = 0;
    accepted = 1'b0;
    while (!accepted) begin
      if (backpressure) begin
        wb_ready_i = (k >= int'(STEPS) + 5) ? 1'b1 : rand_bit();
      end
      rdy = (k >= int'(STEPS) + 1);
      settle_outputs();
      if (rdy) begin
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
      end
      accepted = ex_ready_o;
      close_cycle(rdy);
      k++;
      if (k > int'(STEPS) + 12) begin
        fail_run("Multiplier never returned ready for a high product");
      end
    end
  endtask

  task automatic run_fwd_select();
    logic [DATA_W:0] alu_exp;
    word_t           exp;
    repeat (N_FWD) begin
      idle_inputs();
      alu_en_i            = rand_bit();
      alu_operator_i      = alu_op_e'(4'($urandom_range(0, 15)));
      alu_operand_a_i     = $urandom();
      alu_operand_b_i     = $urandom();
      mult_en_i           = rand_bit();
      mult_operand_a_i    = $urandom();
      mult_operand_b_i    = $urandom();
      csr_access_i        = rand_bit();
      csr_rdata_i         = $urandom();
      regfile_alu_we_i    = rand_bit();
      regfile_alu_waddr_i = 6'($urandom_range(0, 63));
      branch_in_ex_i      = rand_bit();
      lsu_ready_ex_i      = rand_bit();
      wb_ready_i          = rand_bit();
      alu_exp = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      // CSR first, then the multiplier, then the ALU
      if (csr_access_i) begin
        exp = csr_rdata_i;
      end else if (mult_en_i) begin
        exp = mult_model(MULT_MUL, mult_operand_a_i, mult_operand_b_i);
      end else if (alu_en_i) begin
        exp = alu_exp[DATA_W-1:0];
      end else begin
        exp = '0;
      end
      settle_outputs();
      check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
      check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, regfile_alu_we_i);
      check_word("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw_o),
                 32'(regfile_alu_waddr_i));
      close_cycle(1'b1);
    end
  endtask

  // Write port itself is checked in close_cycle one cycle later
  task automatic run_load_port();
    repeat (N_LOAD) begin
      idle_inputs();
      lsu_en_i        = ($urandom_range(0, 3) != 0);
      lsu_err_i       = ($urandom_range(0, 3) == 0);
      lsu_ready_ex_i  = ($urandom_range(0, 3) != 0);
      wb_ready_i      = ($urandom_range(0, 3) != 0);
      lsu_rdata_i     = $urandom();
      regfile_we_i    = rand_bit();
      regfile_waddr_i = 6'($urandom_range(0, 63));
      settle_outputs();
      close_cycle(1'b1);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'hb064f125));
    rst_n       = 1'b0;
    we_model    = 1'b0;
    waddr_model = '0;
    idle_inputs();
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    // Quiet cycle straight after reset
    settle_outputs();
    close_cycle(1'b1);

    run_alu_ops();
    run_mul_ops();
    repeat (N_HIGH) run_high_product(1'b0);
    repeat (N_BP) run_high_product(1'b1);
    run_fwd_select();
    run_load_port();

    $display("all tests passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    fail_run("Timeout, the run did not finish within the expected time");
  end

endmodule
